//--- hdl/pcs_char_pkg.sv
// Clause 82 character and block type codes; byte 0 of a CGMII word is its most significant byte
package pcs_char_pkg;

	// CGMII control characters
	localparam logic [7:0] CGMII_START     = 8'hFB;
	localparam logic [7:0] CGMII_TERMINATE = 8'hFD;
	localparam logic [7:0] CGMII_FSIG      = 8'h5C;
	localparam logic [7:0] CGMII_Q         = 8'h9C;
	localparam logic [7:0] CGMII_IDLE      = 8'h07;
	localparam logic [7:0] CGMII_ERROR     = 8'hFE;

	// PCS control codes (7 bits) and O codes (4 bits)
	localparam logic [6:0] PCS_IDLE  = 7'h00;
	localparam logic [6:0] PCS_ERROR = 7'h1E;
	localparam logic [3:0] PCS_Q     = 4'h0;
	localparam logic [3:0] PCS_FSIG  = 4'hF;

	// Sync headers
	localparam logic [1:0] DATA_SH = 2'b01;
	localparam logic [1:0] CTRL_SH = 2'b10;

	// Block type field
	localparam logic [7:0] BTYPE_CTRL  = 8'h1E;
	localparam logic [7:0] BTYPE_S     = 8'h78;
	localparam logic [7:0] BTYPE_ORDER = 8'h4B;
	localparam logic [7:0] BTYPE_T0    = 8'h87;
	localparam logic [7:0] BTYPE_T1    = 8'h99;
	localparam logic [7:0] BTYPE_T2    = 8'hAA;
	localparam logic [7:0] BTYPE_T3    = 8'hB4;
	localparam logic [7:0] BTYPE_T4    = 8'hCC;
	localparam logic [7:0] BTYPE_T5    = 8'hD2;
	localparam logic [7:0] BTYPE_T6    = 8'hE1;
	localparam logic [7:0] BTYPE_T7    = 8'hFF;

	// Control block made of eight /E/ characters
	localparam logic [65:0] E_BLOCK = {CTRL_SH, BTYPE_CTRL, {8{PCS_ERROR}}};

endpackage

//--- hdl/pcs_cfg_pkg.sv
// Widths fit the 64b/66b transmit path only; T_TYPE is one-hot with all zero meaning E
package pcs_cfg_pkg;

	// Default bus widths
	localparam int NB_DATA_RAW   = 64;
	localparam int NB_CTRL_RAW   = 8;
	localparam int NB_DATA_CODED = 66;
	localparam int NB_TTYPE      = 4;
	localparam int NB_SCR_STATE  = 58;

	// Bit positions in T_TYPE, ordered D S C T from the top
	localparam int TTYPE_D = 3;
	localparam int TTYPE_S = 2;
	localparam int TTYPE_C = 1;
	localparam int TTYPE_T = 0;

	// Transmit state machine
	typedef enum logic [2:0] {
		TX_INIT,
		TX_C,
		TX_D,
		TX_T,
		TX_E
	} tx_state_t;

endpackage

//--- hdl/encoder_comparator.sv
// Output is valid one cycle after an accepted transfer; any unknown block becomes the error block
`timescale 1ns/10ps

module encoder_comparator
	import pcs_char_pkg::*, pcs_cfg_pkg::*;
#(
	parameter int NB_DATA_CODED = pcs_cfg_pkg::NB_DATA_CODED,
	parameter int NB_DATA_RAW   = pcs_cfg_pkg::NB_DATA_RAW,
	parameter int NB_CTRL_RAW   = pcs_cfg_pkg::NB_CTRL_RAW
)
(
	input  logic                     i_clock,
	input  logic                     i_reset,
	input  logic                     i_valid,
	input  logic [NB_DATA_RAW-1:0]   i_tx_data,
	input  logic [NB_CTRL_RAW-1:0]   i_tx_ctrl,
	input  logic                     i_enable,
	output logic [NB_TTYPE-1:0]      o_tx_type,
	output logic [NB_DATA_CODED-1:0] o_tx_coded,
	output logic                     o_valid
);

	localparam int NB_CHAR      = 8;
	localparam int NB_PCS_CHAR  = 7;
	localparam int N_CHARS      = NB_DATA_RAW / NB_CHAR;
	localparam int N_BLOCK_TYPE = N_CHARS + 5;

	// Control mask with only byte 0 flagged as control
	localparam logic [NB_CTRL_RAW-1:0] CTRL_LEAD = {1'b1, {(NB_CTRL_RAW-1){1'b0}}};

	localparam logic [7:0] BTYPE_TERM [N_CHARS] = '{
		BTYPE_T0, BTYPE_T1, BTYPE_T2, BTYPE_T3,
		BTYPE_T4, BTYPE_T5, BTYPE_T6, BTYPE_T7
	};

	logic [NB_DATA_RAW-1:0]  tx_data;
	logic [NB_CTRL_RAW-1:0]  tx_ctrl;
	logic [NB_CHAR-1:0]      cgmii_char [N_CHARS];
	logic [NB_PCS_CHAR-1:0]  pcs_char [N_CHARS];
	logic [N_CHARS-1:0]      char_ok;
	logic [N_CHARS-1:0]      term_hit;
	logic                    type_data;
	logic                    type_s;
	logic                    type_q;
	logic                    type_fsig;
	logic                    type_idle;
	logic [N_BLOCK_TYPE-1:0] block_type;

	// Returns {mapped, pcs code}; only /I/ and /E/ map
	function automatic logic [NB_PCS_CHAR:0] map_char(input logic [NB_CHAR-1:0] char_in);
		case (char_in)
			CGMII_IDLE:  return {1'b1, PCS_IDLE};
			CGMII_ERROR: return {1'b1, PCS_ERROR};
			default:     return '0;
		endcase
	endfunction

	// Input register, loaded only on accepted transfers
	always_ff @(posedge i_clock)
	begin
		if (i_valid && i_enable)
		begin
			tx_data <= i_tx_data;
			tx_ctrl <= i_tx_ctrl;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			o_valid <= 1'b0;
		else
			o_valid <= i_valid && i_enable;
	end

	// Split into characters, char 0 first on the wire
	always_comb
	begin
		for (int k = 0; k < N_CHARS; k++)
		begin
			cgmii_char[k] = tx_data[NB_DATA_RAW-1-NB_CHAR*k -: NB_CHAR];
			{char_ok[k], pcs_char[k]} = map_char(cgmii_char[k]);
		end
	end

	// Terminate in char k needs chars k..7 flagged as control and all chars after /T/ mapped
	always_comb
	begin
		logic trail_ok;
		for (int k = 0; k < N_CHARS; k++)
		begin
			trail_ok = 1'b1;
			for (int j = k + 1; j < N_CHARS; j++)
				trail_ok &= char_ok[j];
			term_hit[k] = (tx_ctrl == ({NB_CTRL_RAW{1'b1}} >> k))
				&& (cgmii_char[k] == CGMII_TERMINATE) && trail_ok;
		end
	end

	assign type_data = (tx_ctrl == '0);
	assign type_s    = (tx_ctrl == CTRL_LEAD) && (cgmii_char[0] == CGMII_START);
	assign type_q    = (tx_ctrl == CTRL_LEAD) && (cgmii_char[0] == CGMII_Q);
	assign type_fsig = (tx_ctrl == CTRL_LEAD) && (cgmii_char[0] == CGMII_FSIG);
	assign type_idle = (tx_ctrl == '1) && (tx_data == {N_CHARS{CGMII_IDLE}});

	// One-hot, or all zero for an unrecognized block
	assign block_type = {type_data, type_s, type_q, type_fsig, type_idle, term_hit};

	// T_TYPE from the type vector
	assign o_tx_type[TTYPE_D] = block_type[N_CHARS+4];
	assign o_tx_type[TTYPE_S] = block_type[N_CHARS+3];
	assign o_tx_type[TTYPE_C] = |block_type[N_CHARS+2:N_CHARS];
	assign o_tx_type[TTYPE_T] = |block_type[N_CHARS-1:0];

	// Block assembly
	always_comb
	begin
		logic [NB_DATA_RAW-1:0] term_payload;
		term_payload = '0;
		o_tx_coded   = E_BLOCK;
		if (type_data)
			o_tx_coded = {DATA_SH, tx_data};
		else if (type_s)
			o_tx_coded = {CTRL_SH, BTYPE_S, tx_data[NB_DATA_RAW-NB_CHAR-1:0]};
		else if (type_q)
			o_tx_coded = {CTRL_SH, BTYPE_ORDER, tx_data[NB_DATA_RAW-NB_CHAR-1 -: 24], PCS_Q, 28'd0};
		else if (type_fsig)
			o_tx_coded = {CTRL_SH, BTYPE_ORDER, tx_data[NB_DATA_RAW-NB_CHAR-1 -: 24], PCS_FSIG,
				28'd0};
		else if (type_idle)
			o_tx_coded = {CTRL_SH, BTYPE_CTRL, {N_CHARS{PCS_IDLE}}};
		else
		begin
			for (int k = 0; k < N_CHARS; k++)
			begin
				if (term_hit[k])
				begin
					term_payload[NB_DATA_RAW-1 -: NB_CHAR] = BTYPE_TERM[k];
					// Data bytes before /T/, zero pad, then the mapped control codes
					for (int j = 0; j < k; j++)
						term_payload[NB_DATA_RAW-NB_CHAR-1-NB_CHAR*j -: NB_CHAR] = cgmii_char[j];
					for (int m = k + 1; m < N_CHARS; m++)
						term_payload[NB_PCS_CHAR*(N_CHARS-m)-1 -: NB_PCS_CHAR] = pcs_char[m];
					o_tx_coded = {CTRL_SH, term_payload};
				end
			end
		end
	end

endmodule

//--- hdl/tx_encode_fsm.sv
// Checks only the order of block types, with no look-ahead past the current block
`timescale 1ns/10ps

module tx_encode_fsm
	import pcs_char_pkg::*, pcs_cfg_pkg::*;
#(
	parameter int NB_DATA_CODED = pcs_cfg_pkg::NB_DATA_CODED
)
(
	input  logic                     i_clock,
	input  logic                     i_reset,
	input  logic                     i_enable,
	input  logic                     i_valid,
	input  logic [NB_TTYPE-1:0]      i_tx_type,
	input  logic [NB_DATA_CODED-1:0] i_tx_coded,
	output logic [NB_DATA_CODED-1:0] o_tx_coded,
	output logic                     o_valid
);

	tx_state_t state;
	tx_state_t state_next;
	logic      accept;
	logic      is_d;
	logic      is_s;
	logic      is_c;
	logic      is_t;

	assign accept = i_valid && i_enable;
	assign is_d   = i_tx_type[TTYPE_D];
	assign is_s   = i_tx_type[TTYPE_S];
	assign is_c   = i_tx_type[TTYPE_C];
	assign is_t   = i_tx_type[TTYPE_T];

	always_comb
	begin
		state_next = TX_E;
		case (state)
			TX_INIT, TX_C, TX_T:
			begin
				if (is_c)
					state_next = TX_C;
				else if (is_s)
					state_next = TX_D;
			end
			TX_D:
			begin
				if (is_d)
					state_next = TX_D;
				else if (is_t)
					state_next = TX_T;
			end
			TX_E:
			begin
				// Recovery on any recognized block
				if (is_c)
					state_next = TX_C;
				else if (is_d || is_s)
					state_next = TX_D;
				else if (is_t)
					state_next = TX_T;
			end
			default:
				state_next = TX_E;
		endcase
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state   <= TX_INIT;
			o_valid <= 1'b0;
		end
		else
		begin
			o_valid <= accept;
			if (accept)
				state <= state_next;
		end
	end

	// Illegal blocks are replaced on the way through
	always_ff @(posedge i_clock)
	begin
		if (accept)
			o_tx_coded <= (state_next == TX_E) ? E_BLOCK : i_tx_coded;
	end

endmodule

//--- hdl/tx_scrambler.sv
// Scrambles all 64 payload bits per cycle, LSB first; the state advances only on accepted blocks
`timescale 1ns/10ps

module tx_scrambler
	import pcs_cfg_pkg::*;
#(
	parameter int NB_DATA_RAW = pcs_cfg_pkg::NB_DATA_RAW
)
(
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_enable,
	input  logic                   i_valid,
	input  logic [NB_DATA_RAW+1:0] i_tx_coded,
	output logic [NB_DATA_RAW+1:0] o_tx_coded,
	output logic                   o_valid
);

	// Taps for 1 + x^39 + x^58
	localparam int TAP_LOW  = 38;
	localparam int TAP_HIGH = NB_SCR_STATE - 1;

	logic [NB_SCR_STATE-1:0] scr_state;
	logic [NB_SCR_STATE-1:0] scr_next;
	logic [NB_DATA_RAW-1:0]  scr_payload;
	logic                    accept;

	assign accept = i_valid && i_enable;

	// Each scrambled bit is shifted back into the state
	always_comb
	begin
		scr_next = scr_state;
		for (int i = 0; i < NB_DATA_RAW; i++)
		begin
			scr_payload[i] = i_tx_coded[i] ^ scr_next[TAP_LOW] ^ scr_next[TAP_HIGH];
			scr_next = {scr_next[NB_SCR_STATE-2:0], scr_payload[i]};
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			scr_state <= '1;
			o_valid   <= 1'b0;
		end
		else
		begin
			o_valid <= accept;
			if (accept)
				scr_state <= scr_next;
		end
	end

	// Sync header is passed through as is
	always_ff @(posedge i_clock)
	begin
		if (accept)
			o_tx_coded <= {i_tx_coded[NB_DATA_RAW+1 -: 2], scr_payload};
	end

endmodule

//--- hdl/pcs_tx.sv
// Three-cycle latency from an accepted CGMII transfer to o_tx_coded; no back-pressure
`timescale 1ns/10ps

module pcs_tx
	import pcs_cfg_pkg::*;
#(
	parameter int NB_DATA_CODED = pcs_cfg_pkg::NB_DATA_CODED,
	parameter int NB_DATA_RAW   = pcs_cfg_pkg::NB_DATA_RAW,
	parameter int NB_CTRL_RAW   = pcs_cfg_pkg::NB_CTRL_RAW
)
(
	input  logic                     i_clock,
	input  logic                     i_reset,
	input  logic                     i_enable,
	input  logic                     i_valid,
	input  logic [NB_DATA_RAW-1:0]   i_tx_data,
	input  logic [NB_CTRL_RAW-1:0]   i_tx_ctrl,
	output logic [NB_DATA_CODED-1:0] o_tx_coded,
	output logic                     o_valid
);

	logic [NB_TTYPE-1:0]      enc_tx_type;
	logic [NB_DATA_CODED-1:0] enc_tx_coded;
	logic                     enc_valid;
	logic [NB_DATA_CODED-1:0] fsm_tx_coded;
	logic                     fsm_valid;

	encoder_comparator
	#(
		.NB_DATA_CODED (NB_DATA_CODED),
		.NB_DATA_RAW   (NB_DATA_RAW),
		.NB_CTRL_RAW   (NB_CTRL_RAW)
	)
	u_encoder_comparator
	(
		.i_clock    (i_clock),
		.i_reset    (i_reset),
		.i_valid    (i_valid),
		.i_tx_data  (i_tx_data),
		.i_tx_ctrl  (i_tx_ctrl),
		.i_enable   (i_enable),
		.o_tx_type  (enc_tx_type),
		.o_tx_coded (enc_tx_coded),
		.o_valid    (enc_valid)
	);

	tx_encode_fsm #(.NB_DATA_CODED (NB_DATA_CODED)) u_tx_encode_fsm
	(
		.i_clock    (i_clock),
		.i_reset    (i_reset),
		.i_enable   (i_enable),
		.i_valid    (enc_valid),
		.i_tx_type  (enc_tx_type),
		.i_tx_coded (enc_tx_coded),
		.o_tx_coded (fsm_tx_coded),
		.o_valid    (fsm_valid)
	);

	tx_scrambler #(.NB_DATA_RAW (NB_DATA_RAW)) u_tx_scrambler
	(
		.i_clock    (i_clock),
		.i_reset    (i_reset),
		.i_enable   (i_enable),
		.i_valid    (fsm_valid),
		.i_tx_coded (fsm_tx_coded),
		.o_tx_coded (o_tx_coded),
		.o_valid    (o_valid)
	);

endmodule

//--- testbench/tb_pcs_tx_assert.sv
// Bound to pcs_tx; a block reaches the output only if i_enable stays high while it is in flight
`timescale 1ns/10ps

module tb_pcs_tx_assert
	import pcs_char_pkg::*;
(
	input logic        i_clock,
	input logic        i_reset,
	input logic        i_enable,
	input logic        i_valid,
	input logic [65:0] o_tx_coded,
	input logic        o_valid
);

	// Output register was cleared by reset on the previous edge
	assert property (@(posedge i_clock) $past(i_reset) |-> !o_valid)
	else
		$error("o_valid high after a reset edge");

	assert property (@(posedge i_clock) disable iff (i_reset)
		o_valid |-> (o_tx_coded[65:64] == DATA_SH || o_tx_coded[65:64] == CTRL_SH))
	else
		$error("invalid sync header %b", o_tx_coded[65:64]);

	// Accepted three samples back, enable kept for the two later stages
	assert property (@(posedge i_clock) disable iff (i_reset)
		(!$past(i_reset, 1) && !$past(i_reset, 2) && !$past(i_reset, 3))
		|-> (o_valid == ($past(i_valid && i_enable, 3) && $past(i_enable, 2)
			&& $past(i_enable, 1))))
	else
		$error("o_valid does not follow the accepted input by three edges");

endmodule

//--- testbench/tb_pcs_tx.sv
// Expects all accepted rows to survive; enable-low rows are preceded by two bubbles so none are lost
`timescale 1ns/10ps

module tb_pcs_tx
	import pcs_char_pkg::*, pcs_cfg_pkg::*;
();

	localparam int RESET_CYCLES = 3;
	localparam int LATENCY      = 3;
	localparam int MARGIN       = 20;

	typedef struct {
		string       name;
		logic [63:0] data;
		logic [7:0]  ctrl;
		bit          valid;
		bit          enable;
		logic [65:0] exp;
	} row_t;

	logic        i_clock;
	logic        i_reset;
	logic        i_enable;
	logic        i_valid;
	logic [63:0] i_tx_data;
	logic [7:0]  i_tx_ctrl;
	logic [65:0] o_tx_coded;
	logic        o_valid;

	row_t        rows[$];
	int          exp_row_q[$];
	int          exp_edge_q[$];
	logic [31:0] rng_state;
	logic [57:0] dscr_state;
	int          cur_row;
	int          cycle_count;
	int          cycle_limit;
	int          errors;
	int          n_checked;
	int          n_failed;

	logic [7:0] btype_term [8] = '{
		BTYPE_T0, BTYPE_T1, BTYPE_T2, BTYPE_T3,
		BTYPE_T4, BTYPE_T5, BTYPE_T6, BTYPE_T7
	};

	pcs_tx i_pcs_tx
	(
		.i_clock    (i_clock),
		.i_reset    (i_reset),
		.i_enable   (i_enable),
		.i_valid    (i_valid),
		.i_tx_data  (i_tx_data),
		.i_tx_ctrl  (i_tx_ctrl),
		.o_tx_coded (o_tx_coded),
		.o_valid    (o_valid)
	);

	bind pcs_tx tb_pcs_tx_assert u_tb_pcs_tx_assert
	(
		.i_clock    (i_clock),
		.i_reset    (i_reset),
		.i_enable   (i_enable),
		.i_valid    (i_valid),
		.o_tx_coded (o_tx_coded),
		.o_valid    (o_valid)
	);

	always #10 i_clock = ~i_clock;

	always @(posedge i_clock)
		cycle_count <= cycle_count + 1;

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic add_row(input string name, input logic [63:0] data, input logic [7:0] ctrl,
		input bit valid, input bit enable, input logic [65:0] exp);
		row_t r;
		r.name   = name;
		r.data   = data;
		r.ctrl   = ctrl;
		r.valid  = valid;
		r.enable = enable;
		r.exp    = exp;
		rows.push_back(r);
	endtask

	task automatic add_idle(input string name);
		add_row(name, {8{CGMII_IDLE}}, 8'hFF, 1, 1, {CTRL_SH, BTYPE_CTRL, {8{PCS_IDLE}}});
	endtask

	task automatic add_start(input string name, input logic [65:0] exp_override, input bit use_ovr);
		logic [63:0] r;
		r = {next_random(), next_random()};
		r[63:56] = CGMII_START;
		add_row(name, r, 8'h80, 1, 1, use_ovr ? exp_override : {CTRL_SH, BTYPE_S, r[55:0]});
	endtask

	task automatic add_data(input string name, input logic [65:0] exp_override, input bit use_ovr);
		logic [63:0] r;
		r = {next_random(), next_random()};
		add_row(name, r, 8'h00, 1, 1, use_ovr ? exp_override : {DATA_SH, r});
	endtask

	// Terminate in char k; err_tail puts /E/ in the last char
	task automatic add_term(input string name, input int k, input bit err_tail);
		logic [63:0] d;
		logic [55:0] payload;
		logic [6:0]  code;
		payload = '0;
		for (int j = 0; j < 8; j++)
		begin
			if (j < k)
				d[63-8*j -: 8] = next_random();
			else if (j == k)
				d[63-8*j -: 8] = CGMII_TERMINATE;
			else
				d[63-8*j -: 8] = (err_tail && j == 7) ? CGMII_ERROR : CGMII_IDLE;
		end
		// Data bytes follow the type field, control codes sit at the bottom
		for (int j = 0; j < k; j++)
			payload[55-8*j -: 8] = d[63-8*j -: 8];
		for (int m = k + 1; m < 8; m++)
		begin
			code = (err_tail && m == 7) ? PCS_ERROR : PCS_IDLE;
			payload[7*(7-m)+6 -: 7] = code;
		end
		add_row(name, d, 8'hFF >> k, 1, 1, {CTRL_SH, btype_term[k], payload});
	endtask

	task automatic add_order(input string name, input logic [7:0] cchar, input logic [3:0] ocode);
		logic [23:0] r;
		r = next_random();
		add_row(name, {cchar, r, 32'h0}, 8'h80, 1, 1, {CTRL_SH, BTYPE_ORDER, r, ocode, 28'd0});
	endtask

	task automatic build_table();
		add_idle("idle after reset");
		for (int k = 0; k < 8; k++)
		begin
			add_start($sformatf("start before T%0d", k), '0, 0);
			add_data($sformatf("data before T%0d", k), '0, 0);
			add_term($sformatf("terminate T%0d", k), k, k == 5);
			add_idle($sformatf("idle after T%0d", k));
		end
		add_order("ordered set Q", CGMII_Q, PCS_Q);
		add_idle("idle after Q");
		add_order("ordered set Fsig", CGMII_FSIG, PCS_FSIG);
		add_idle("idle after Fsig");
		// Illegal orders
		add_data("data after idle", E_BLOCK, 1);
		add_idle("idle recovers");
		add_start("start", '0, 0);
		add_start("start after start", E_BLOCK, 1);
		add_idle("idle recovers again");
		add_row("terminate after idle", {CGMII_TERMINATE, {7{CGMII_IDLE}}}, 8'hFF, 1, 1, E_BLOCK);
		add_idle("idle after bad terminate");
		// Malformed control
		add_start("start before bad tail", '0, 0);
		add_data("data before bad tail", '0, 0);
		add_row("terminate with bad tail", {16'h1122, CGMII_TERMINATE, CGMII_IDLE, CGMII_IDLE,
			8'h55, CGMII_IDLE, CGMII_IDLE}, 8'h3F, 1, 1, E_BLOCK);
		add_idle("idle after bad tail");
		add_row("unknown control mask", {next_random(), next_random()}, 8'hA5, 1, 1, E_BLOCK);
		add_idle("idle after bad mask");
		// Enable gating
		add_row("bubble 1", '0, 8'h00, 0, 1, '0);
		add_row("bubble 2", '0, 8'h00, 0, 1, '0);
		add_row("gated row 1", {next_random(), next_random()}, 8'h00, 1, 0, '0);
		add_row("gated row 2", {next_random(), next_random()}, 8'h00, 1, 0, '0);
		add_idle("idle after gating");
	endtask

	task automatic check_value(input string name, input logic [65:0] got, input logic [65:0] exp);
		if (got !== exp)
		begin
			$display("ERROR %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// Reference descrambler for 1 + x^39 + x^58
	function automatic logic [65:0] descramble(input logic [65:0] blk);
		logic [63:0] plain;
		for (int i = 0; i < 64; i++)
		begin
			plain[i] = blk[i] ^ dscr_state[38] ^ dscr_state[57];
			dscr_state = {dscr_state[56:0], blk[i]};
		end
		return {blk[65:64], plain};
	endfunction

	// Inputs and outputs are both stable at the falling edge
	always @(negedge i_clock)
	begin
		int          row;
		int          err_before;
		logic [65:0] plain;
		if (!i_reset && o_valid)
		begin
			if (exp_row_q.size() == 0)
			begin
				$display("o_valid went high with no accepted row in flight");
				errors++;
				n_failed++;
			end
			else
			begin
				row        = exp_row_q.pop_front();
				err_before = errors;
				check_value("latency", cycle_count - exp_edge_q.pop_front(), LATENCY);
				plain = descramble(o_tx_coded);
				check_value("o_tx_coded", plain, rows[row].exp);
				n_checked++;
				if (errors != err_before)
					n_failed++;
				$display("row %0d %s: %s", row, rows[row].name,
					(errors == err_before) ? "ok" : "mismatch");
			end
		end
		// Row was applied on the last rising edge
		if (!i_reset && i_valid && i_enable)
		begin
			exp_row_q.push_back(cur_row);
			exp_edge_q.push_back(cycle_count);
		end
	end

	always @(posedge i_clock)
	begin
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("Timeout after %0d cycles with %0d rows still in flight", cycle_count,
				exp_row_q.size());
			$display("Simulation failed");
			$finish;
		end
	end

	initial
	begin
		i_clock     = 1'b0;
		i_reset     = 1'b1;
		i_enable    = 1'b0;
		i_valid     = 1'b0;
		i_tx_data   = '0;
		i_tx_ctrl   = '0;
		rng_state   = 32'h5ffc;
		dscr_state  = '1;
		cur_row     = 0;
		cycle_count = 0;
		cycle_limit = 0;
		errors      = 0;
		n_checked   = 0;
		n_failed    = 0;
		build_table();
		cycle_limit = RESET_CYCLES + rows.size() + LATENCY + MARGIN;
		repeat (RESET_CYCLES) @(posedge i_clock);
		i_reset <= 1'b0;
		foreach (rows[i])
		begin
			i_tx_data <= rows[i].data;
			i_tx_ctrl <= rows[i].ctrl;
			i_valid   <= rows[i].valid;
			i_enable  <= rows[i].enable;
			cur_row   <= i;
			@(posedge i_clock);
		end
		i_valid  <= 1'b0;
		i_enable <= 1'b1;
		@(negedge i_clock);
		@(negedge i_clock);
		wait (exp_row_q.size() == 0);
		@(negedge i_clock);
		$display("Checked %0d blocks, %0d failed, %0d errors", n_checked, n_failed, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- tb.f
hdl/pcs_char_pkg.sv
hdl/pcs_cfg_pkg.sv
hdl/encoder_comparator.sv
hdl/tx_encode_fsm.sv
hdl/tx_scrambler.sv
hdl/pcs_tx.sv
testbench/tb_pcs_tx_assert.sv
testbench/tb_pcs_tx.sv

//--- Bender.yml
package:
  name: pcs_tx

sources:
  - files:
      - hdl/pcs_char_pkg.sv
      - hdl/pcs_cfg_pkg.sv
      - hdl/encoder_comparator.sv
      - hdl/tx_encode_fsm.sv
      - hdl/tx_scrambler.sv
      - hdl/pcs_tx.sv
  - target: test
    files:
      - testbench/tb_pcs_tx_assert.sv
      - testbench/tb_pcs_tx.sv
